/* source/map_config.svh */
`ifndef MAP_CONFIG_SVH
`define MAP_CONFIG_SVH

// logical screen, half of the 640x480 vga raster
`define MAP_SCREEN_W 320
`define MAP_SCREEN_H 240

`define MAP_ROM_STRIDE 320    // sprite rom row width
`define MAP_BLANK_ADDR 12900  // empty rom texel

// step periods in clocks, one step every ticks+1 cycles
`define MAP_H_STEP_TICKS 2000000
`define MAP_V_STEP_TICKS 1500000

`define MAP_H_DISP_MAX 282    // last disp_h that may still step right

// player 1 box in static pose, logical pixels
`define MAP_PLAYER_H0 13
`define MAP_PLAYER_W 15
`define MAP_PLAYER_V0 200
`define MAP_PLAYER_HT 30
`define MAP_PLAYER_ROM_H 40   // rom column offset of the sprite

`define MAP_LED_BASE 16'h000F // low nibble always lit

`endif

/* source/map_pkg.sv */
`default_nettype none

package map_pkg;

    typedef logic [9:0] coord_t;     // pixel coord, raw or halved
    typedef logic [16:0] rom_addr_t;

    // movement codes from game logic, anything else is no move
    typedef enum logic [3:0] {
        st_idle  = 4'd6,
        st_right = 4'd7,
        st_left  = 4'd8,
        st_up    = 4'd9
    } player_state_t;

    typedef enum logic [1:0] {
        jump_none = 2'd0,
        jump_rise = 2'd1,
        jump_fall = 2'd2     // 3 never used
    } jump_t;

    typedef struct packed {
        coord_t pivot_h;     // screen corner
        coord_t pivot_v;
        coord_t width;
        coord_t height;
        coord_t rom_h;       // matching corner in rom
        coord_t rom_v;
    } terrain_rect_t;

    localparam int terrain_count = 14;

    // priority order, first match wins
    localparam terrain_rect_t terrain_table [terrain_count] = '{
        '{10'd0,   10'd0,   10'd320, 10'd10,  10'd0,   10'd220}, // ceiling
        '{10'd150, 10'd230, 10'd40,  10'd6,   10'd0,   10'd65},  // red river
        '{10'd210, 10'd230, 10'd40,  10'd6,   10'd55,  10'd70},  // blue river
        '{10'd190, 10'd182, 10'd40,  10'd6,   10'd165, 10'd1},   // green river
        '{10'd0,   10'd230, 10'd320, 10'd10,  10'd0,   10'd220}, // floor
        '{10'd0,   10'd10,  10'd10,  10'd220, 10'd305, 10'd10},  // left boundary
        '{10'd310, 10'd10,  10'd10,  10'd220, 10'd305, 10'd10},  // right boundary
        '{10'd10,  10'd182, 10'd240, 10'd8,   10'd50,  10'd215}, // wall 1
        '{10'd50,  10'd139, 10'd260, 10'd8,   10'd0,   10'd220}, // wall 2
        '{10'd60,  10'd96,  10'd210, 10'd8,   10'd0,   10'd220}, // wall 3
        '{10'd160, 10'd89,  10'd50,  10'd7,   10'd0,   10'd220}, // wall 4
        '{10'd110, 10'd48,  10'd200, 10'd8,   10'd0,   10'd220}, // wall 6
        '{10'd250, 10'd19,  10'd23,  10'd29,  10'd0,   10'd89},  // red door
        '{10'd280, 10'd19,  10'd21,  10'd29,  10'd32,  10'd89}   // blue door
    };

endpackage

`default_nettype wire

/* source/player_status.sv */
`default_nettype none
`include "map_config.svh"

module player_status #(
    parameter int h_step_ticks = `MAP_H_STEP_TICKS,
    parameter int v_step_ticks = `MAP_V_STEP_TICKS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  map_pkg::player_state_t player_state,
    input  map_pkg::jump_t         player_jump,
    output map_pkg::coord_t        disp_h,
    output map_pkg::coord_t        disp_v,
    output logic [15:0]            led
);
    import map_pkg::*;

    // +2 keeps at least one bit when ticks is 0
    localparam int hcw = $clog2(h_step_ticks + 2);
    localparam int vcw = $clog2(v_step_ticks + 2);
    localparam logic [hcw-1:0] h_top = hcw'(h_step_ticks);
    localparam logic [vcw-1:0] v_top = vcw'(v_step_ticks);

    logic [hcw-1:0] cnt_h;
    logic [vcw-1:0] cnt_v;
    logic           h_move;  // right or left
    logic           v_move;  // right, left or up
    logic           h_tick;
    logic           v_tick;
    logic [3:0]     led_hi;

    assign h_move = (player_state == st_right) || (player_state == st_left);
    assign v_move = h_move || (player_state == st_up);
    assign h_tick = (cnt_h == h_top); // counter never passes top
    assign v_tick = (cnt_v == v_top);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_h  <= '0;
            disp_h <= '0;
        end else if (player_state == st_idle) begin
            cnt_h <= '0; // idle restarts the step period
        end else if (h_move) begin
            if (!h_tick) begin
                cnt_h <= cnt_h + 1'b1;
            end else begin
                cnt_h <= '0;
                if (player_state == st_right && disp_h <= coord_t'(`MAP_H_DISP_MAX)) begin
                    disp_h <= disp_h + 1'b1; // stops at 283
                end else if (player_state == st_left && disp_h != '0) begin
                    disp_h <= disp_h - 1'b1;
                end
            end
        end
    end

    // vertical follows the jump phase, rise has no ceiling
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt_v  <= '0;
            disp_v <= '0;
        end else if (v_move) begin
            case (player_jump)
                jump_none: cnt_v <= '0;
                jump_rise, jump_fall: begin
                    if (!v_tick) begin
                        cnt_v <= cnt_v + 1'b1;
                    end else begin
                        cnt_v <= '0;
                        if (player_jump == jump_rise) begin
                            disp_v <= disp_v + 1'b1; // wraps at 10 bits
                        end else if (disp_v != '0) begin
                            disp_v <= disp_v - 1'b1;
                        end
                    end
                end
                default: cnt_v <= cnt_v; // phase 3 holds
            endcase
        end
    end

    always_comb begin
        case (player_state)
            st_idle:  led_hi = 4'b1000;
            st_right: led_hi = 4'b1100;
            st_left:  led_hi = 4'b1110;
            st_up:    led_hi = 4'b1111;
            default:  led_hi = 4'b0000;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) led <= `MAP_LED_BASE;
        else     led <= {led_hi, 12'h000} | `MAP_LED_BASE;
    end

endmodule

`default_nettype wire

/* source/terrain_lookup.sv */
`default_nettype none
`include "map_config.svh"

module terrain_lookup (
    input  logic               clk,
    input  logic               rst,
    input  map_pkg::coord_t    vga_h,
    input  map_pkg::coord_t    vga_v,
    output map_pkg::coord_t    pix_h,        // halved, one cycle late
    output map_pkg::coord_t    pix_v,
    output logic               terrain_hit,
    output map_pkg::rom_addr_t terrain_addr
);
    import map_pkg::*;

    coord_t    h;
    coord_t    v;
    logic      hit_c;
    rom_addr_t addr_c;

    assign h = vga_h >> 1; // 640x480 down to 320x240
    assign v = vga_v >> 1;

    // half open box, 11 bit sums so the right edge cannot wrap
    function automatic logic inside_rect(coord_t ph, coord_t pv, terrain_rect_t r);
        return (ph >= r.pivot_h) && ({1'b0, ph} < {1'b0, r.pivot_h} + {1'b0, r.width})
            && (pv >= r.pivot_v) && ({1'b0, pv} < {1'b0, r.pivot_v} + {1'b0, r.height});
    endfunction

    // priority scan, lowest index wins
    always_comb begin
        hit_c  = 1'b0;
        addr_c = '0;
        for (int i = 0; i < terrain_count; i++) begin
            if (!hit_c && inside_rect(h, v, terrain_table[i])) begin
                hit_c  = 1'b1;
                addr_c = (rom_addr_t'(h) - rom_addr_t'(terrain_table[i].pivot_h)
                          + rom_addr_t'(terrain_table[i].rom_h))
                       + (rom_addr_t'(v) - rom_addr_t'(terrain_table[i].pivot_v)
                          + rom_addr_t'(terrain_table[i].rom_v))
                         * rom_addr_t'(`MAP_ROM_STRIDE);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_h        <= '0;
            pix_v        <= '0;
            terrain_hit  <= 1'b0;
            terrain_addr <= '0;
        end else begin
            pix_h        <= h;
            pix_v        <= v;
            terrain_hit  <= hit_c;
            terrain_addr <= addr_c;
        end
    end

endmodule

`default_nettype wire

/* source/sprite_compose.sv */
`default_nettype none
`include "map_config.svh"

module sprite_compose (
    input  logic                   clk,
    input  logic                   rst,
    input  map_pkg::coord_t        pix_h,
    input  map_pkg::coord_t        pix_v,
    input  logic                   terrain_hit,
    input  map_pkg::rom_addr_t     terrain_addr,
    input  map_pkg::coord_t        disp_h,
    input  map_pkg::coord_t        disp_v,
    input  map_pkg::player_state_t player_state,
    output map_pkg::rom_addr_t     addr
);
    import map_pkg::*;

    logic [10:0] box_l;    // left edge after shift
    logic [10:0] box_r;    // right edge, exclusive
    logic [10:0] v_lift;   // pix_v + disp_v
    logic        in_box;
    rom_addr_t   sprite_addr;

    assign box_l = {1'b0, disp_h} + 11'(`MAP_PLAYER_H0);
    assign box_r = box_l + 11'(`MAP_PLAYER_W);

    // v0-disp_v <= v < v0+ht-disp_v, with disp_v moved to the pixel side
    assign v_lift = {1'b0, pix_v} + {1'b0, disp_v};

    assign in_box = ({1'b0, pix_h} >= box_l) && ({1'b0, pix_h} < box_r)
                 && (v_lift >= 11'(`MAP_PLAYER_V0))
                 && (v_lift < 11'(`MAP_PLAYER_V0 + `MAP_PLAYER_HT));

    assign sprite_addr = (rom_addr_t'(pix_h) + rom_addr_t'(`MAP_PLAYER_ROM_H) - rom_addr_t'(disp_h))
                       + (rom_addr_t'(v_lift) - rom_addr_t'(`MAP_PLAYER_V0))
                         * rom_addr_t'(`MAP_ROM_STRIDE);

    // terrain in front, player only in static pose
    always_ff @(posedge clk or posedge rst) begin
        if (rst)                                    addr <= rom_addr_t'(`MAP_BLANK_ADDR);
        else if (terrain_hit)                       addr <= terrain_addr;
        else if (player_state == st_idle && in_box) addr <= sprite_addr;
        else                                        addr <= rom_addr_t'(`MAP_BLANK_ADDR);
    end

endmodule

`default_nettype wire

/* source/map_renderer.sv */
`default_nettype none
`include "map_config.svh"

module map_renderer #(
    parameter int h_step_ticks = `MAP_H_STEP_TICKS,
    parameter int v_step_ticks = `MAP_V_STEP_TICKS
) (
    input  logic                   clk,
    input  logic                   rst,
    input  map_pkg::coord_t        vga_h,
    input  map_pkg::coord_t        vga_v,
    input  map_pkg::player_state_t player_state,
    input  map_pkg::jump_t         player_jump,
    output map_pkg::rom_addr_t     addr,  // two clocks behind vga_h/vga_v
    output logic [15:0]            led
);
    map_pkg::coord_t    pix_h;
    map_pkg::coord_t    pix_v;
    logic               terrain_hit;
    map_pkg::rom_addr_t terrain_addr;
    map_pkg::coord_t    disp_h;      // player 1 offset
    map_pkg::coord_t    disp_v;

    player_status #(
        .h_step_ticks (h_step_ticks),
        .v_step_ticks (v_step_ticks)
    ) status_i (
        .clk          (clk),
        .rst          (rst),
        .player_state (player_state),
        .player_jump  (player_jump),
        .disp_h       (disp_h),
        .disp_v       (disp_v),
        .led          (led)
    );

    // stage 1
    terrain_lookup lookup_i (
        .clk          (clk),
        .rst          (rst),
        .vga_h        (vga_h),
        .vga_v        (vga_v),
        .pix_h        (pix_h),
        .pix_v        (pix_v),
        .terrain_hit  (terrain_hit),
        .terrain_addr (terrain_addr)
    );

    // stage 2
    sprite_compose compose_i (
        .clk          (clk),
        .rst          (rst),
        .pix_h        (pix_h),
        .pix_v        (pix_v),
        .terrain_hit  (terrain_hit),
        .terrain_addr (terrain_addr),
        .disp_h       (disp_h),
        .disp_v       (disp_v),
        .player_state (player_state),
        .addr         (addr)
    );

endmodule

`default_nettype wire

/* tests/map_checker.sv */
`default_nettype none
`include "map_config.svh"

module map_checker #(
    parameter int h_step_ticks = 7,
    parameter int v_step_ticks = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  map_pkg::coord_t        vga_h,
    input  map_pkg::coord_t        vga_v,
    input  map_pkg::player_state_t player_state,
    input  map_pkg::jump_t         player_jump,
    input  map_pkg::rom_addr_t     addr,
    input  logic [15:0]            led,
    output int                     checks,
    output int                     addr_errors,
    output int                     led_errors
);
    timeunit 1ns;
    timeprecision 100ps;
    import map_pkg::*;

    int          disp_h, disp_v;  // model displacement
    int          cnt_h, cnt_v;    // step counters
    int          prev_h, prev_v;  // raw pixel from the edge before
    bit          prev_ok;         // stage 1 holds a driven pixel
    rom_addr_t   exp_addr;
    logic [15:0] exp_led;

    // table scan in priority order, then the idle sprite, else blank
    function automatic int expect_addr(int vh, int vv, int dh, int dv, player_state_t st);
        terrain_rect_t r;
        int            h;
        int            v;
        int            res;
        h   = vh / 2;
        v   = vv / 2;
        res = -1;
        for (int i = 0; i < terrain_count; i++) begin
            r = terrain_table[i];
            if (res < 0 && h >= int'(r.pivot_h) && h < int'(r.pivot_h) + int'(r.width)
                && v >= int'(r.pivot_v) && v < int'(r.pivot_v) + int'(r.height))
                res = (h - int'(r.pivot_h) + int'(r.rom_h))
                    + (v - int'(r.pivot_v) + int'(r.rom_v)) * `MAP_ROM_STRIDE;
        end
        if (res < 0 && st == st_idle
            && h >= `MAP_PLAYER_H0 + dh && h < `MAP_PLAYER_H0 + `MAP_PLAYER_W + dh
            && v >= `MAP_PLAYER_V0 - dv && v < `MAP_PLAYER_V0 + `MAP_PLAYER_HT - dv)
            res = (h + `MAP_PLAYER_ROM_H - dh) + (v + dv - `MAP_PLAYER_V0) * `MAP_ROM_STRIDE;
        return (res < 0) ? `MAP_BLANK_ADDR : res;
    endfunction

    function automatic logic [15:0] expect_led(player_state_t st);
        logic [3:0] hi;
        case (st)
            st_idle:  hi = 4'h8;
            st_right: hi = 4'hC;
            st_left:  hi = 4'hE;
            st_up:    hi = 4'hF;
            default:  hi = 4'h0;  // no-move codes
        endcase
        return {hi, 12'h00F};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            disp_h   = 0;
            disp_v   = 0;
            cnt_h    = 0;
            cnt_v    = 0;
            prev_ok  = 1'b0;
            exp_addr = rom_addr_t'(`MAP_BLANK_ADDR);
            exp_led  = `MAP_LED_BASE;
        end else begin
            checks++;  // outputs still show the previous edge here
            if (addr !== exp_addr) begin
                addr_errors++;
                $display("** Error addr_check: expected %0d, actual %0d at %0t",
                         exp_addr, addr, $time);
            end
            if (led !== exp_led) begin
                led_errors++;
                $display("** Error led_check: expected %h, actual %h at %0t", exp_led, led, $time);
            end
            // stage 2 uses the pixel from one edge back with the current disp and state
            exp_addr = prev_ok
                ? rom_addr_t'(expect_addr(prev_h, prev_v, disp_h, disp_v, player_state))
                : rom_addr_t'(`MAP_BLANK_ADDR);
            exp_led  = expect_led(player_state);
            if (player_state == st_idle) begin
                cnt_h = 0;
            end else if (player_state == st_right || player_state == st_left) begin
                if (cnt_h < h_step_ticks) begin
                    cnt_h++;
                end else begin
                    cnt_h = 0;
                    if (player_state == st_right && disp_h <= `MAP_H_DISP_MAX) disp_h++;
                    else if (player_state == st_left && disp_h >= 1) disp_h--;
                end
            end
            if (player_state == st_right || player_state == st_left || player_state == st_up) begin
                if (player_jump == jump_none) begin
                    cnt_v = 0;
                end else if (player_jump == jump_rise || player_jump == jump_fall) begin
                    if (cnt_v < v_step_ticks) begin
                        cnt_v++;
                    end else begin
                        cnt_v = 0;
                        if (player_jump == jump_rise) disp_v = (disp_v + 1) % 1024;  // 10 bit wrap
                        else if (disp_v > 0) disp_v--;
                    end
                end
            end
            prev_h  = int'(vga_h);
            prev_v  = int'(vga_v);
            prev_ok = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* tests/map_renderer_sva.sv */
`default_nettype none
`include "map_config.svh"

module map_renderer_sva (
    input logic               clk,
    input logic               rst,
    input map_pkg::rom_addr_t addr,
    input logic [15:0]        led
);
    timeunit 1ns;
    timeprecision 100ps;
    import map_pkg::*;

    // first edge out of reset still shows the reset values
    assert property (@(posedge clk) $fell(rst) |-> addr == rom_addr_t'(`MAP_BLANK_ADDR))
        else $error("addr not blank on the first edge after reset");
    assert property (@(posedge clk) $fell(rst) |-> led == `MAP_LED_BASE)
        else $error("led not at base pattern on the first edge after reset");

    assert property (@(posedge clk) disable iff (rst) led[3:0] == 4'hF)
        else $error("led low nibble went dark");
    assert property (@(posedge clk) disable iff (rst)
                     addr < rom_addr_t'(`MAP_SCREEN_W * `MAP_SCREEN_H))
        else $error("addr beyond the sprite rom");

endmodule

bind map_renderer map_renderer_sva sva_i (.clk(clk), .rst(rst), .addr(addr), .led(led));

`default_nettype wire

/* tests/tb_map_renderer.sv */
`default_nettype none

module tb_map_renderer;
    timeunit 1ns;
    timeprecision 100ps;
    import map_pkg::*;

    localparam int reset_cycles = 5;
    localparam int run_cycles   = 24000;  // long enough to reach both h limits
    localparam int clk_period   = 4;

    logic          clk;
    logic          rst;
    coord_t        vga_h;
    coord_t        vga_v;
    player_state_t player_state;
    jump_t         player_jump;
    rom_addr_t     addr;
    logic [15:0]   led;
    int            checks;
    int            addr_errors;
    int            led_errors;
    int            seed;
    int            seg_left;  // cycles left in the current state segment

    // first half drifts right, second half drifts left
    function automatic player_state_t pick_state(int r, bit toward_right);
        player_state_t st;
        case (r)
            0, 1, 2: st = toward_right ? st_right : st_left;
            3:       st = toward_right ? st_left : st_right;
            4, 5:    st = st_idle;
            6:       st = st_up;
            default: st = player_state_t'(4'd3);  // no-move code
        endcase
        return st;
    endfunction

    task automatic drive_pixel();
        if ($unsigned($random(seed)) % 4 == 0) begin
            vga_h = coord_t'($unsigned($random(seed)) % 128);  // around the player box
            vga_v = coord_t'(360 + $unsigned($random(seed)) % 120);
        end else begin
            vga_h = coord_t'($unsigned($random(seed)) % 640);
            vga_v = coord_t'($unsigned($random(seed)) % 480);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        seed         = 32'hea23_9352;
        rst          = 1'b1;
        vga_h        = '0;
        vga_v        = '0;
        player_state = st_idle;
        player_jump  = jump_none;
        seg_left     = 0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < run_cycles; n++) begin
            if (seg_left == 0) begin
                player_state = pick_state(int'($unsigned($random(seed)) % 8), n < run_cycles / 2);
                player_jump  = jump_t'(2'($unsigned($random(seed)) % 4));
                seg_left     = 20 + int'($unsigned($random(seed)) % 181);
            end
            seg_left--;
            drive_pixel();
            @(negedge clk);
        end
        repeat (4) @(negedge clk);  // drain the pipeline
        $display("checks %0d, addr errors %0d, led errors %0d", checks, addr_errors, led_errors);
        if (addr_errors == 0 && led_errors == 0 && checks > 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // watchdog at twice the stimulus length
    initial begin
        #((reset_cycles + run_cycles) * clk_period * 2);
        $display("timeout: stimulus did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

    map_renderer #(.h_step_ticks(7), .v_step_ticks(5)) dut_i (
        .clk (clk), .rst (rst), .vga_h (vga_h), .vga_v (vga_v),
        .player_state (player_state), .player_jump (player_jump),
        .addr (addr), .led (led)
    );

    map_checker #(.h_step_ticks(7), .v_step_ticks(5)) checker_i (
        .clk (clk), .rst (rst), .vga_h (vga_h), .vga_v (vga_v),
        .player_state (player_state), .player_jump (player_jump),
        .addr (addr), .led (led),
        .checks (checks), .addr_errors (addr_errors), .led_errors (led_errors)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/map_pkg.sv
source/player_status.sv
source/terrain_lookup.sv
source/sprite_compose.sv
source/map_renderer.sv
tests/map_checker.sv
tests/map_renderer_sva.sv
tests/tb_map_renderer.sv

/* run.sh */
#!/bin/sh
# build and run the map renderer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_map_renderer -o tb_map_renderer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_map_renderer)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Result: PASSED"; then
    exit 0
fi
exit 1
